// ==== common/usb_cdc_pkg.sv ====
/*
 * usb cdc shared definitions
 * packet ids and the 11-bit token field, read either as
 * address plus endpoint or as an sof frame number
 */

package usb_cdc_pkg;

    // ------------------------------------
    // packet ids, 4-bit form without check bits
    // ------------------------------------
    localparam logic [3:0] pid_out   = 4'b0001;  // token, host to device
    localparam logic [3:0] pid_in    = 4'b1001;  // token, device to host
    localparam logic [3:0] pid_sof   = 4'b0101;  // start of frame
    localparam logic [3:0] pid_data0 = 4'b0011;  // data, toggle 0
    localparam logic [3:0] pid_data1 = 4'b1011;  // data, toggle 1
    localparam logic [3:0] pid_ack   = 4'b0010;  // handshake ok
    localparam logic [3:0] pid_nak   = 4'b1010;  // handshake, nothing to send

    // ------------------------------------
    // token payload
    // ------------------------------------

    // endpoint sits above the address, as on the wire after lsb-first unpacking
    typedef struct packed {
        logic [3:0] ep;    // endpoint number
        logic [6:0] addr;  // device address
    } usb_ep_addr_t;

    // IN/OUT tokens carry ep_addr, SOF carries frame
    typedef union packed {
        usb_ep_addr_t ep_addr;  // IN and OUT
        logic [10:0]  frame;    // SOF
    } usb_token_field_t;

endpackage

// ==== hdl/send_buffer.sv ====
/*
 * send buffer, device-to-host byte fifo
 * ring of 2^ASIZE bytes with registered read side,
 * send_ready drops when full
 */

`timescale 1ns/1ps

module send_buffer #(
    parameter int ASIZE = 10                 // depth = 2^ASIZE bytes
) (
    input  logic       clk,
    input  logic       usb_rstn,
    input  logic [7:0] send_data,            // byte from user
    input  logic       send_valid,
    output logic       send_ready,           // low only when full
    output logic [7:0] buf_data,             // head byte, registered
    output logic       buf_valid,            // head byte present
    input  logic       buf_pop               // pulse, head consumed
);

    logic [7:0]   mem [0:(1<<ASIZE)-1];     // maps to block ram
    logic [ASIZE:0] wptr;                    // extra msb for wrap
    logic [ASIZE:0] rptr;
    logic         wr_en;

    // full when pointers differ only in the wrap bit
    assign send_ready = (wptr != {~rptr[ASIZE], rptr[ASIZE-1:0]});
    assign wr_en      = send_valid && send_ready;

    // ------------------------------------
    // write side
    // ------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wptr <= '0;
        end else if (wr_en) begin
            wptr <= wptr + 1'b1;             // advance on accepted byte
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr[ASIZE-1:0]] <= send_data;
        end
    end

    // ------------------------------------
    // read side
    // ------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            rptr      <= '0;
            buf_valid <= 1'b0;
        end else if (buf_pop) begin
            rptr      <= rptr + 1'b1;
            buf_valid <= 1'b0;               // hide stale head for a cycle
        end else begin
            buf_valid <= (wptr != rptr);     // re-evaluate after the gap
        end
    end

    always_ff @(posedge clk) begin
        buf_data <= mem[rptr[ASIZE-1:0]];    // follows rptr one cycle late
    end

endmodule

// ==== hdl/token_decoder.sv ====
/*
 * token decoder
 * matches IN/OUT tokens against device address and cdc endpoint,
 * latches the frame number of SOF tokens
 */

`timescale 1ns/1ps

module token_decoder #(
    parameter int CDC_EP = 1                          // data pipe endpoint
) (
    input  logic                           clk,
    input  logic                           usb_rstn,
    input  logic                           tok_valid,     // token strobe
    input  logic [3:0]                     tok_pid,
    input  usb_cdc_pkg::usb_token_field_t  tok_field,
    input  logic [6:0]                     dev_addr,      // assigned address
    output logic                           tok_in,        // pulse, IN for us
    output logic                           tok_out,       // pulse, OUT for us
    output logic [10:0]                    frame_number   // last sof frame
);

    import usb_cdc_pkg::*;

    logic addr_hit;   // address field matches
    logic ep_hit;     // endpoint field matches

    // only meaningful for IN/OUT, ignored otherwise
    assign addr_hit = (tok_field.ep_addr.addr == dev_addr);
    assign ep_hit   = (tok_field.ep_addr.ep == 4'(CDC_EP));

    // ------------------------------------
    // pid decode
    // ------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            tok_in       <= 1'b0;
            tok_out      <= 1'b0;
            frame_number <= '0;
        end else begin
            tok_in  <= 1'b0;                           // pulses by default
            tok_out <= 1'b0;
            if (tok_valid) begin
                case (tok_pid)
                    pid_in:  tok_in  <= addr_hit && ep_hit;
                    pid_out: tok_out <= addr_hit && ep_hit;
                    pid_sof: frame_number <= tok_field.frame;  // no address on sof
                    default: ;                         // other pids dropped
                endcase
            end
        end
    end

endmodule

// ==== hdl/ep_in_packetizer.sv ====
/*
 * IN endpoint packetizer
 * answers IN tokens with a DATA0/DATA1 packet drawn from the
 * send buffer, or NAK when the buffer is empty
 */

`timescale 1ns/1ps

module ep_in_packetizer #(
    parameter int EP_IN_MAXPKT = 32          // max payload bytes
) (
    input  logic       clk,
    input  logic       usb_rstn,
    input  logic       tok_in,               // pulse from token decoder
    input  logic [7:0] buf_data,
    input  logic       buf_valid,
    output logic       buf_pop,              // pulse, take head byte
    output logic       tx_pid_valid,
    output logic [3:0] tx_pid,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    output logic       tx_eop                // pulse after last byte
);

    import usb_cdc_pkg::*;

    localparam int cnt_w = $clog2(EP_IN_MAXPKT + 1);

    // ------------------------------------
    // fsm encoding
    // ------------------------------------
    localparam logic [2:0] st_idle = 3'd0;   // waiting for IN
    localparam logic [2:0] st_pid  = 3'd1;   // pid on the bus
    localparam logic [2:0] st_data = 3'd2;   // pop if buffer has a byte
    localparam logic [2:0] st_wait = 3'd3;   // buffer valid gap after pop
    localparam logic [2:0] st_end  = 3'd4;   // send eop, flip toggle

    logic [2:0]       state;
    logic [cnt_w-1:0] byte_cnt;              // bytes in current packet
    logic             toggle;                // 0 = DATA0, 1 = DATA1
    logic             last_byte;

    assign buf_pop   = (state == st_data) && buf_valid;
    assign last_byte = (byte_cnt == cnt_w'(EP_IN_MAXPKT - 1));

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state        <= st_idle;
            byte_cnt     <= '0;
            toggle       <= 1'b0;
            tx_pid_valid <= 1'b0;
            tx_valid     <= 1'b0;
            tx_eop       <= 1'b0;
        end else begin
            tx_pid_valid <= 1'b0;            // strobes default low
            tx_valid     <= 1'b0;
            tx_eop       <= 1'b0;
            case (state)
                st_idle: begin
                    if (tok_in) begin
                        tx_pid_valid <= 1'b1;
                        byte_cnt     <= '0;
                        // nak stays in idle, no eop
                        state        <= buf_valid ? st_pid : st_idle;
                    end
                end
                st_pid: begin
                    state <= st_data;
                end
                st_data: begin
                    if (buf_valid) begin
                        tx_valid <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= last_byte ? st_end : st_wait;
                    end else begin
                        state <= st_end;     // buffer ran dry, short packet
                    end
                end
                st_wait: begin
                    state <= st_data;
                end
                st_end: begin
                    tx_eop <= 1'b1;
                    toggle <= ~toggle;       // no retransmit, flip every packet
                    state  <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ------------------------------------
    // payload registers
    // ------------------------------------
    always_ff @(posedge clk) begin
        if (state == st_idle && tok_in) begin
            tx_pid <= buf_valid ? (toggle ? pid_data1 : pid_data0) : pid_nak;
        end
        if (buf_pop) begin
            tx_data <= buf_data;
        end
    end

endmodule

// ==== hdl/ep_out_receiver.sv ====
/*
 * OUT endpoint receiver
 * forwards bytes of OUT data packets, drops duplicates by
 * data toggle, acknowledges every packet
 */

`timescale 1ns/1ps

module ep_out_receiver (
    input  logic       clk,
    input  logic       usb_rstn,
    input  logic       tok_out,              // pulse, OUT token for us
    input  logic       rx_pid_valid,         // start of data packet
    input  logic [3:0] rx_pid,
    input  logic       rx_valid,             // payload byte strobe
    input  logic [7:0] rx_data,
    input  logic       rx_eop,               // end of data packet
    output logic       recv_valid,
    output logic [7:0] recv_data,
    output logic       out_ack               // pulse per acked packet
);

    import usb_cdc_pkg::*;

    logic armed;      // OUT token seen, waiting for data pid
    logic in_pkt;     // inside an accepted data packet
    logic fwd;        // toggle matched, pass bytes on
    logic toggle;     // expected toggle, 0 = DATA0
    logic exp_pid;    // rx_pid equals expected data pid

    assign exp_pid = (rx_pid == (toggle ? pid_data1 : pid_data0));

    // ------------------------------------
    // packet tracking
    // ------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            armed      <= 1'b0;
            in_pkt     <= 1'b0;
            fwd        <= 1'b0;
            toggle     <= 1'b0;
            recv_valid <= 1'b0;
            out_ack    <= 1'b0;
        end else begin
            recv_valid <= 1'b0;
            out_ack    <= 1'b0;
            if (tok_out) begin
                armed <= 1'b1;
            end
            if (rx_pid_valid && armed) begin
                in_pkt <= 1'b1;
                fwd    <= exp_pid;           // mismatch means host resent
            end
            if (rx_valid && in_pkt) begin
                recv_valid <= fwd;           // duplicates swallowed here
            end
            if (rx_eop && in_pkt) begin
                out_ack <= 1'b1;             // ack duplicates too
                if (fwd) begin
                    toggle <= ~toggle;
                end
                armed  <= 1'b0;
                in_pkt <= 1'b0;
                fwd    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            recv_data <= rx_data;
        end
    end

endmodule

// ==== hdl/usb_serial_top.sv ====
/*
 * usb cdc serial data path, packet level
 * send buffer, token decoder, IN packetizer and OUT receiver
 */

`timescale 1ns/1ps

module usb_serial_top #(
    parameter int ASIZE        = 10,         // send buffer 2^ASIZE bytes
    parameter int EP_IN_MAXPKT = 32,         // max IN payload
    parameter int CDC_EP       = 1           // data pipe endpoint
) (
    input  logic                           clk,
    input  logic                           usb_rstn,
    // host side, tokens
    input  logic                           tok_valid,
    input  logic [3:0]                     tok_pid,
    input  usb_cdc_pkg::usb_token_field_t  tok_field,
    input  logic [6:0]                     dev_addr,
    output logic [10:0]                    frame_number,
    // host side, OUT data
    input  logic                           rx_pid_valid,
    input  logic [3:0]                     rx_pid,
    input  logic                           rx_valid,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_eop,
    output logic                           out_ack,
    // host side, IN data
    output logic                           tx_pid_valid,
    output logic [3:0]                     tx_pid,
    output logic                           tx_valid,
    output logic [7:0]                     tx_data,
    output logic                           tx_eop,
    // user side
    input  logic [7:0]                     send_data,
    input  logic                           send_valid,
    output logic                           send_ready,
    output logic [7:0]                     recv_data,
    output logic                           recv_valid
);

    logic [7:0] buf_data;   // buffer head
    logic       buf_valid;
    logic       buf_pop;
    logic       tok_in;     // decoded IN for cdc ep
    logic       tok_out;    // decoded OUT for cdc ep

    // ------------------------------------
    // device-to-host
    // ------------------------------------
    send_buffer #(
        .ASIZE      (ASIZE)
    ) i_send_buffer (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .send_data  (send_data),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .buf_data   (buf_data),
        .buf_valid  (buf_valid),
        .buf_pop    (buf_pop)
    );

    ep_in_packetizer #(
        .EP_IN_MAXPKT (EP_IN_MAXPKT)
    ) i_ep_in_packetizer (
        .clk          (clk),
        .usb_rstn     (usb_rstn),
        .tok_in       (tok_in),
        .buf_data     (buf_data),
        .buf_valid    (buf_valid),
        .buf_pop      (buf_pop),
        .tx_pid_valid (tx_pid_valid),
        .tx_pid       (tx_pid),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .tx_eop       (tx_eop)
    );

    // ------------------------------------
    // tokens and host-to-device
    // ------------------------------------
    token_decoder #(
        .CDC_EP       (CDC_EP)
    ) i_token_decoder (
        .clk          (clk),
        .usb_rstn     (usb_rstn),
        .tok_valid    (tok_valid),
        .tok_pid      (tok_pid),
        .tok_field    (tok_field),
        .dev_addr     (dev_addr),
        .tok_in       (tok_in),
        .tok_out      (tok_out),
        .frame_number (frame_number)
    );

    ep_out_receiver i_ep_out_receiver (
        .clk          (clk),
        .usb_rstn     (usb_rstn),
        .tok_out      (tok_out),
        .rx_pid_valid (rx_pid_valid),
        .rx_pid       (rx_pid),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_eop       (rx_eop),
        .recv_valid   (recv_valid),
        .recv_data    (recv_data),
        .out_ack      (out_ack)
    );

endmodule

// ==== test/usb_serial_asserts.sv ====
/*
 * usb serial assertions, bound to the top level
 * bus strobe exclusivity, recv after rx, quiet strobes in reset
 */

`timescale 1ns/1ps

module usb_serial_asserts (
    input logic clk,
    input logic usb_rstn,
    input logic tx_pid_valid,
    input logic tx_valid,
    input logic tx_eop,
    input logic rx_valid,
    input logic recv_valid,
    input logic out_ack
);

    // pid and payload share one host bus
    a_tx_exclusive: assert property (@(posedge clk) disable iff (!usb_rstn)
        !(tx_valid && tx_pid_valid))
        else $error("tx_valid and tx_pid_valid high in the same cycle");

    // every forwarded byte came in one cycle earlier
    a_recv_from_rx: assert property (@(posedge clk) disable iff (!usb_rstn)
        recv_valid |-> $past(rx_valid))
        else $error("recv_valid without rx_valid in the cycle before");

    a_reset_quiet: assert property (@(posedge clk)
        !usb_rstn |-> !(tx_pid_valid || tx_valid || tx_eop || out_ack || recv_valid))
        else $error("strobe active while usb_rstn is low");

endmodule

bind usb_serial_top usb_serial_asserts i_usb_serial_asserts (
    .clk          (clk),
    .usb_rstn     (usb_rstn),
    .tx_pid_valid (tx_pid_valid),
    .tx_valid     (tx_valid),
    .tx_eop       (tx_eop),
    .rx_valid     (rx_valid),
    .recv_valid   (recv_valid),
    .out_ack      (out_ack)
);

// ==== test/tb_usb_serial.sv ====
/*
 * usb serial data path testbench
 * table of user writes and host tokens, reference fifo for IN data
 */

`timescale 1ns/1ps

module tb_usb_serial;

    import usb_cdc_pkg::*;

    localparam int         buf_asize   = 4;                 // 16 byte send buffer
    localparam int         max_pkt     = 8;                 // IN payload limit
    localparam int         data_ep     = 1;                 // cdc data endpoint
    localparam logic [6:0] my_addr     = 7'h2d;             // device address
    localparam int         reply_wait  = 6;                 // cycles to wait for a pid
    localparam int         ack_wait    = 4;
    localparam int         eop_wait    = 4 * max_pkt + 8;   // two cycles per byte plus slack
    localparam int         step_cycles = 4 * max_pkt + 40; // worst case for one row

    typedef enum {step_send, step_in, step_out, step_sof} step_kind_e;

    typedef struct {
        string       name;
        step_kind_e  kind;
        logic [10:0] field;      // token word
        int          count;      // bytes written or sent
        logic [3:0]  pid;        // token pid for IN, data pid for OUT
        logic        exp_ok;     // ready, reply or ack expected
        logic [3:0]  exp_pid;    // IN reply pid
        int          exp_len;    // IN payload, OUT bytes forwarded
    } step_t;

    logic             clk;
    logic             usb_rstn;
    logic             tok_valid;
    logic [3:0]       tok_pid;
    usb_token_field_t tok_field;
    logic [6:0]       dev_addr;
    logic [10:0]      frame_number;
    logic             rx_pid_valid;
    logic [3:0]       rx_pid;
    logic             rx_valid;
    logic [7:0]       rx_data;
    logic             rx_eop;
    logic             out_ack;
    logic             tx_pid_valid;
    logic [3:0]       tx_pid;
    logic             tx_valid;
    logic [7:0]       tx_data;
    logic             tx_eop;
    logic [7:0]       send_data;
    logic             send_valid;
    logic             send_ready;
    logic [7:0]       recv_data;
    logic             recv_valid;

    step_t       steps[$];                // the stimulus table
    logic [7:0]  ref_q[$];                // bytes written, not yet sent
    logic [3:0]  pid_q[$];                // seen on the bus, negedge samples
    logic [7:0]  tx_q[$];
    logic [7:0]  recv_q[$];
    int          eop_cnt;
    int          ack_cnt;
    logic        ready_s;
    logic [10:0] frame_s;
    integer      seed        = 32'h8d4d_615c;
    int          cycle_cnt   = 0;
    int          cycle_limit = 1000;      // replaced once the table is built

    usb_serial_top #(
        .ASIZE        (buf_asize),
        .EP_IN_MAXPKT (max_pkt),
        .CDC_EP       (data_ep)
    ) i_usb_serial_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // monitor, samples mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        ready_s = send_ready;
        frame_s = frame_number;
        if (usb_rstn) begin
            if (tx_pid_valid) pid_q.push_back(tx_pid);
            if (tx_valid) tx_q.push_back(tx_data);
            if (tx_eop) eop_cnt++;
            if (out_ack) ack_cnt++;
            if (recv_valid) recv_q.push_back(recv_data);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            stop_with_failure("run exceeded its cycle limit, the DUT stopped responding");
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            stop_with_failure("value mismatch, run stopped");
        end
    endtask

    function automatic logic [10:0] token_word(input logic [3:0] ep, input logic [6:0] addr);
        usb_token_field_t f;
        f.ep_addr.ep   = ep;
        f.ep_addr.addr = addr;
        return f;
    endfunction

    task automatic add_step(input string name, input step_kind_e kind,
                            input logic [10:0] field, input int count, input logic [3:0] pid,
                            input logic exp_ok, input logic [3:0] exp_pid, input int exp_len);
        steps.push_back('{name, kind, field, count, pid, exp_ok, exp_pid, exp_len});
    endtask

    // user writes, ready checked as the DUT saw it
    task automatic send_bytes(input step_t s);
        logic [7:0] b;
        int         i;
        for (i = 0; i < s.count; i++) begin
            b = 8'($random(seed));
            send_data  <= b;
            send_valid <= 1'b1;
            @(posedge clk);
            check_value(s.name, s.exp_ok, ready_s);
            if (s.exp_ok) ref_q.push_back(b);      // taken at this edge
        end
        send_valid <= 1'b0;
    endtask

    task automatic send_token(input logic [3:0] pid, input logic [10:0] field);
        tok_valid <= 1'b1;
        tok_pid   <= pid;
        tok_field <= field;
        @(posedge clk);
        tok_valid <= 1'b0;
    endtask

    task automatic issue_in(input step_t s);
        int waited;
        int i;
        pid_q.delete();
        tx_q.delete();
        recv_q.delete();
        eop_cnt = 0;
        ack_cnt = 0;
        send_token(s.pid, s.field);
        waited = 0;
        while (pid_q.size() == 0 && waited < reply_wait) begin
            @(posedge clk);
            waited++;
        end
        if (!s.exp_ok) begin
            check_value(s.name, 0, pid_q.size());                  // foreign token
        end else if (pid_q.size() == 0) begin
            stop_with_failure("no PID reply to an IN token for this device");
        end else begin
            check_value(s.name, 2, waited);                        // decode, then pid
            check_value(s.name, s.exp_pid, pid_q[0]);
            if (s.exp_pid == pid_nak) begin
                repeat (3) @(posedge clk);
                check_value(s.name, 0, eop_cnt + tx_q.size());     // nak has no body
            end else begin
                waited = 0;
                while (eop_cnt == 0 && waited < eop_wait) begin
                    @(posedge clk);
                    waited++;
                end
                if (eop_cnt == 0) begin
                    stop_with_failure("IN data packet never ended with tx_eop");
                end else begin
                    check_value(s.name, s.exp_len, tx_q.size());
                    for (i = 0; i < tx_q.size(); i++) begin
                        check_value(s.name, ref_q.pop_front(), tx_q[i]);  // fifo order
                    end
                end
            end
        end
    endtask

    task automatic issue_out(input step_t s);
        logic [7:0] sent_q[$];
        logic [7:0] b;
        int         waited;
        int         i;
        recv_q.delete();
        pid_q.delete();
        ack_cnt = 0;
        send_token(pid_out, s.field);
        @(posedge clk);                            // receiver arms here
        rx_pid_valid <= 1'b1;
        rx_pid       <= s.pid;
        for (i = 0; i < s.count; i++) begin
            b = 8'($random(seed));
            @(posedge clk);
            rx_pid_valid <= 1'b0;
            rx_valid     <= 1'b1;
            rx_data      <= b;
            sent_q.push_back(b);
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        rx_eop   <= 1'b1;
        @(posedge clk);
        rx_eop <= 1'b0;
        waited = 0;
        while (ack_cnt == 0 && waited < ack_wait) begin
            @(posedge clk);
            waited++;
        end
        check_value(s.name, s.exp_ok, ack_cnt);
        check_value(s.name, 0, pid_q.size());      // IN side stays quiet
        check_value(s.name, s.exp_len, recv_q.size());
        for (i = 0; i < recv_q.size(); i++) begin
            check_value(s.name, sent_q[i], recv_q[i]);
        end
    endtask

    task automatic issue_sof(input step_t s);
        pid_q.delete();
        send_token(pid_sof, s.field);
        @(posedge clk);
        check_value(s.name, s.field, frame_s);     // frame one cycle after token
        repeat (3) @(posedge clk);
        check_value(s.name, 0, pid_q.size());      // no address on sof
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [10:0] good_tok;
        logic [10:0] bad_addr_tok;
        logic [10:0] bad_ep_tok;
        int          n;
        usb_rstn     = 1'b1;
        tok_valid    = 1'b0;
        tok_pid      = 4'h0;
        tok_field    = '0;
        dev_addr     = my_addr;
        rx_pid_valid = 1'b0;
        rx_pid       = 4'h0;
        rx_valid     = 1'b0;
        rx_data      = 8'h00;
        rx_eop       = 1'b0;
        send_data    = 8'h00;
        send_valid   = 1'b0;
        eop_cnt      = 0;
        ack_cnt      = 0;

        good_tok     = token_word(4'(data_ep), my_addr);
        bad_addr_tok = token_word(4'(data_ep), my_addr ^ 7'h01);
        bad_ep_tok   = token_word(4'd2, my_addr);

        add_step("reset_nak",      step_in,   good_tok,     0,  pid_in,    1'b1, pid_nak,   0);
        add_step("fill_13",        step_send, 11'h0,        13, 4'h0,      1'b1, 4'h0,      0);
        add_step("in_data0_8",     step_in,   good_tok,     0,  pid_in,    1'b1, pid_data0, 8);
        add_step("in_data1_5",     step_in,   good_tok,     0,  pid_in,    1'b1, pid_data1, 5);
        add_step("in_empty_nak",   step_in,   good_tok,     0,  pid_in,    1'b1, pid_nak,   0);
        add_step("fill_16",        step_send, 11'h0,        16, 4'h0,      1'b1, 4'h0,      0);
        add_step("full_refuse",    step_send, 11'h0,        1,  4'h0,      1'b0, 4'h0,      0);
        add_step("drain_data0",    step_in,   good_tok,     0,  pid_in,    1'b1, pid_data0, 8);
        add_step("drain_data1",    step_in,   good_tok,     0,  pid_in,    1'b1, pid_data1, 8);
        add_step("drain_nak",      step_in,   good_tok,     0,  pid_in,    1'b1, pid_nak,   0);
        add_step("space_again",    step_send, 11'h0,        1,  4'h0,      1'b1, 4'h0,      0);
        add_step("in_after_full",  step_in,   good_tok,     0,  pid_in,    1'b1, pid_data0, 1);
        add_step("in_wrong_addr",  step_in,   bad_addr_tok, 0,  pid_in,    1'b0, 4'h0,      0);
        add_step("in_wrong_ep",    step_in,   bad_ep_tok,   0,  pid_in,    1'b0, 4'h0,      0);
        add_step("out_wrong_addr", step_out,  bad_addr_tok, 3,  pid_data0, 1'b0, 4'h0,      0);
        add_step("out_wrong_ep",   step_out,  bad_ep_tok,   3,  pid_data0, 1'b0, 4'h0,      0);
        add_step("out_data0",      step_out,  good_tok,     4,  pid_data0, 1'b1, 4'h0,      4);
        add_step("out_dup_data0",  step_out,  good_tok,     4,  pid_data0, 1'b1, 4'h0,      0);
        add_step("out_data1",      step_out,  good_tok,     5,  pid_data1, 1'b1, 4'h0,      5);
        add_step("sof_like_token", step_sof,  good_tok,     0,  pid_sof,   1'b1, 4'h0,      0);
        add_step("sof_frame",      step_sof,  11'h532,      0,  pid_sof,   1'b1, 4'h0,      0);
        add_step("send_after_sof", step_send, 11'h0,        2,  4'h0,      1'b1, 4'h0,      0);
        add_step("in_after_sof",   step_in,   good_tok,     0,  pid_in,    1'b1, pid_data1, 2);
        add_step("out_after_sof",  step_out,  good_tok,     3,  pid_data0, 1'b1, 4'h0,      3);
        cycle_limit = steps.size() * step_cycles + 40;

        #1 usb_rstn = 1'b0;                        // clean falling edge
        repeat (3) @(posedge clk);
        usb_rstn <= 1'b1;
        @(posedge clk);
        check_value("reset_ready", 1, ready_s);

        for (n = 0; n < steps.size(); n++) begin
            case (steps[n].kind)
                step_send: send_bytes(steps[n]);
                step_in:   issue_in(steps[n]);
                step_out:  issue_out(steps[n]);
                default:   issue_sof(steps[n]);
            endcase
            @(posedge clk);                        // idle gap between rows
        end

        if (ref_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure("written bytes were never sent to the host");
        end
    end

endmodule

// ==== compile.f ====
common/usb_cdc_pkg.sv
hdl/send_buffer.sv
hdl/token_decoder.sv
hdl/ep_in_packetizer.sv
hdl/ep_out_receiver.sv
hdl/usb_serial_top.sv
test/usb_serial_asserts.sv
test/tb_usb_serial.sv
